//--- list.f
+incdir+source
source/pad_dma_pkg.sv
source/pad_dma_if.sv
source/block_sequencer.sv
source/tile_reader.sv
source/pad_writer.sv
source/pad_dma_top.sv
bench/axi_mem_model.sv
bench/pad_dma_tb.sv

//--- Bender.yml
package:
  name: pad_dma

sources:
  - include_dirs:
      - source
    files:
      - source/pad_dma_pkg.sv
      - source/pad_dma_if.sv
      - source/block_sequencer.sv
      - source/tile_reader.sv
      - source/pad_writer.sv
      - source/pad_dma_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/axi_mem_model.sv
      - bench/pad_dma_tb.sv

//--- bench/pad_dma_tb.sv
//////////////////////////////////////////////////
// Randomized regression for the padding DMA
// Source and destination regions must not overlap
// Memory model holds 8192 words from address 0
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pad_dma_macros.svh"

module pad_dma_tb;
    import pad_dma_pkg::*;

    localparam int          MAX_CYCLES = 40000;   // Far above all four jobs with stalls
    localparam logic [15:0] SEED       = 16'd47;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  start_i;
    addr_t                 src_addr_i, dst_addr_i;
    width_t                width_i;
    logic                  done_o;
    addr_t                 araddr_o, awaddr_o;
    logic                  arvalid_o, arready_i, rlast_i, rvalid_i, rready_o;
    word_t                 rdata_i, wdata_o;
    logic [`PD_LEN_W-1:0]  awlen_o;
    logic                  awvalid_o, awready_i, wlast_o, wvalid_o, wready_i;
    logic                  bvalid_i, bready_o;

    logic [4:0]   stall_q    = '0;
    logic         stall_en   = 1'b0;
    logic [15:0]  stall_lfsr = SEED;
    logic [15:0]  data_lfsr  = SEED;
    int           cycle_count = 0;

    // Current job as seen by the write monitor
    int           job_w, job_src_idx, job_dst_idx;
    int           burst_count, min_len, addr_req_count;
    int           cur_idx, cur_len, beat;
    logic [7:0]   wcount   [0:4095];
    word_t        src_copy [0:4095];

    pad_dma_top pad_dma_top_i (.*);

    axi_mem_model mem_model (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall_i   (stall_q),
        .araddr_i  (araddr_o),
        .arvalid_i (arvalid_o),
        .arready_o (arready_i),
        .rdata_o   (rdata_i),
        .rlast_o   (rlast_i),
        .rvalid_o  (rvalid_i),
        .rready_i  (rready_o),
        .awaddr_i  (awaddr_o),
        .awvalid_i (awvalid_o),
        .awready_o (awready_i),
        .wdata_i   (wdata_o),
        .wlast_i   (wlast_o),
        .wvalid_i  (wvalid_o),
        .wready_o  (wready_i),
        .bvalid_o  (bvalid_i),
        .bready_i  (bready_o)
    );

    always #10 clk = ~clk;

    // Taps for x^16 + x^14 + x^13 + x^11 + 1 with the new bit entering at the bottom
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Reflect without repeating the edge element
    function automatic int reflect_index(input int k, input int w);
        if (k < 0) return 1;
        if (k == w) return w - 2;
        return k;
    endfunction

    task automatic report_fail(input string msg);
        $display("Fail %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin : stall_gen
        logic [4:0] bits;
        if (stall_en) begin
            for (int i = 0; i < 5; i++) begin
                stall_lfsr = lfsr_next(stall_lfsr);
                bits[i]    = stall_lfsr[0];
            end
            stall_q <= bits;
        end else begin
            stall_q <= '0;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run passed %0d cycles without finishing", MAX_CYCLES);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    // Write bursts checked beat by beat against the current job
    always @(posedge clk) begin : write_monitor
        int off;
        if (rst_n) begin
            if (arvalid_o || awvalid_o) addr_req_count <= addr_req_count + 1;
            if (arvalid_o && arready_i) begin
                assert (int'(araddr_o >> 2) >= job_src_idx
                        && int'(araddr_o >> 2) + `PD_TILE <= job_src_idx + job_w * job_w)
                    else report_fail($sformatf("read address %h outside source", araddr_o));
            end
            if (awvalid_o && awready_i) begin
                assert (awaddr_o[1:0] == 2'b00 && int'(awaddr_o >> 2) >= job_dst_idx)
                    else report_fail($sformatf("burst address %h outside destination", awaddr_o));
                cur_idx     <= int'(awaddr_o >> 2);
                cur_len     <= int'(awlen_o);
                beat        <= 0;
                burst_count <= burst_count + 1;
                if (int'(awlen_o) < min_len) min_len <= int'(awlen_o);
            end
            if (wvalid_o && wready_i) begin
                off = cur_idx + beat - job_dst_idx;
                assert (wlast_o == (beat == cur_len))
                    else report_fail($sformatf("wlast %b on beat %0d, awlen %0d",
                                               wlast_o, beat, cur_len));
                assert (off < (job_w + 2) * (job_w + 2))
                    else report_fail($sformatf("write beyond destination, offset %0d", off));
                assert (wcount[off] == 0)
                    else report_fail($sformatf("destination offset %0d written twice", off));
                wcount[off] <= wcount[off] + 1'b1;
                beat        <= beat + 1;
            end
        end
    end

    task automatic fill_source(input addr_t base, input int w);
        word_t word;
        for (int i = 0; i < w * w; i++) begin
            word = '0;
            for (int b = 0; b < 32; b++) begin
                data_lfsr = lfsr_next(data_lfsr);
                word      = {word[30:0], data_lfsr[0]};
            end
            src_copy[i] = word;
            mem_model.mem[int'(base >> 2) + i] = word;
        end
    endtask

    task automatic start_job(input addr_t src, input addr_t dst, input int w);
        @(posedge clk);
        start_i    <= 1'b1;
        src_addr_i <= src;
        dst_addr_i <= dst;
        width_i    <= width_t'(w);
        @(posedge clk);
        start_i    <= 1'b0;
    endtask

    // Stray start with other fields while the job runs
    task automatic pulse_busy_start();
        repeat (8) @(posedge clk);
        assert (!done_o) else report_fail("done_o rose before the stray start");
        start_i    <= 1'b1;
        width_i    <= 6'd4;
        dst_addr_i <= 32'h0000_7000;
        @(posedge clk);
        start_i    <= 1'b0;
    endtask

    task automatic check_rejected_starts();
        assert (done_o) else report_fail("done_o low after reset");
        start_i <= 1'b1;
        width_i <= 6'd0;
        @(posedge clk);
        width_i <= 6'd6;
        @(posedge clk);
        start_i <= 1'b0;
        repeat (20) begin
            @(posedge clk);
            assert (done_o) else report_fail("done_o dropped after a rejected start");
        end
        assert (addr_req_count == 0)
            else report_fail($sformatf("%0d address cycles after rejected starts", addr_req_count));
    endtask

    task automatic check_result(input int w);
        word_t expected, got;
        assert (burst_count == (w + 2) * (w / 4))
            else report_fail($sformatf("%0d bursts, expected %0d", burst_count, (w + 2) * (w / 4)));
        if (w == 4) begin
            assert (min_len == 5) else report_fail("single tile burst shorter than 6 beats");
        end
        for (int r = 0; r < w + 2; r++) begin
            for (int c = 0; c < w + 2; c++) begin
                expected = src_copy[reflect_index(r - 1, w) * w + reflect_index(c - 1, w)];
                got      = mem_model.mem[job_dst_idx + r * (w + 2) + c];
                assert (got == expected)
                    else report_fail($sformatf("P[%0d][%0d] is %h, expected %h",
                                               r, c, got, expected));
                assert (wcount[r * (w + 2) + c] == 1)
                    else report_fail($sformatf("P[%0d][%0d] written %0d times",
                                               r, c, wcount[r * (w + 2) + c]));
            end
        end
    endtask

    task automatic run_job(input addr_t src, input addr_t dst, input int w,
                           input logic stalls, input logic stray);
        job_w       = w;
        job_src_idx = int'(src >> 2);
        job_dst_idx = int'(dst >> 2);
        burst_count = 0;
        min_len     = 15;
        for (int i = 0; i < 4096; i++) wcount[i] = '0;
        fill_source(src, w);
        stall_en <= stalls;
        start_job(src, dst, w);
        @(posedge clk);
        assert (!done_o) else report_fail("done_o still high after an accepted start");
        if (stray) pulse_busy_start();
        while (!done_o) @(posedge clk);
        check_result(w);
    endtask

    initial begin
        rst_n          = 1'b0;
        start_i        = 1'b0;
        src_addr_i     = '0;
        dst_addr_i     = '0;
        width_i        = '0;
        job_w          = 4;
        job_src_idx    = 0;
        job_dst_idx    = 0;
        burst_count    = 0;
        min_len        = 15;
        addr_req_count = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        check_rejected_starts();
        run_job(32'h0000_0000, 32'h0000_1000, 4, 1'b0, 1'b0);
        run_job(32'h0000_2000, 32'h0000_3000, 12, 1'b1, 1'b0);
        run_job(32'h0000_4000, 32'h0000_5000, 8, 1'b1, 1'b0);   // Back to back pair
        run_job(32'h0000_5800, 32'h0000_6000, 8, 1'b1, 1'b1);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/axi_mem_model.sv
//////////////////////////////////////////////////
// AXI-style memory responder, word addressed
// Reads are always 4-beat INCR bursts; writes end on wlast
// Stall bits come from the bench, one per channel
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pad_dma_macros.svh"

module axi_mem_model #(
    parameter int MEM_WORDS = 8192
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire [4:0]                 stall_i,     // b, w, aw, r, ar
    input  wire pad_dma_pkg::addr_t   araddr_i,
    input  wire                       arvalid_i,
    output logic                      arready_o,
    output pad_dma_pkg::word_t        rdata_o,
    output logic                      rlast_o,
    output logic                      rvalid_o,
    input  wire                       rready_i,
    input  wire pad_dma_pkg::addr_t   awaddr_i,
    input  wire                       awvalid_i,
    output logic                      awready_o,
    input  wire pad_dma_pkg::word_t   wdata_i,
    input  wire                       wlast_i,
    input  wire                       wvalid_i,
    output logic                      wready_o,
    output logic                      bvalid_o,
    input  wire                       bready_i
);
    import pad_dma_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t             mem [0:MEM_WORDS-1];
    logic              rd_busy, wr_busy, b_pend;
    logic [IDX_W-1:0]  rd_ptr, wr_ptr;
    logic [1:0]        rd_beat;

    // Background pattern, distinct for every word
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {16'hBAD0, 16'(i)};
        end
    end

    assign arready_o = !rd_busy && !stall_i[0];
    assign rdata_o   = mem[rd_ptr];
    assign rlast_o   = (rd_beat == 2'd3);
    assign awready_o = !wr_busy && !stall_i[2];
    assign wready_o  = wr_busy && !b_pend && !stall_i[3];

    // Read channel
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_busy  <= 1'b0;
            rvalid_o <= 1'b0;
            rd_beat  <= '0;
        end else if (!rd_busy) begin
            if (arvalid_i && arready_o) begin
                rd_busy <= 1'b1;
                rd_ptr  <= araddr_i[IDX_W+1:2];
                rd_beat <= '0;
            end
        end else if (rvalid_o && rready_i) begin
            rvalid_o <= 1'b0;
            rd_ptr   <= rd_ptr + 1'b1;
            rd_beat  <= rd_beat + 1'b1;
            if (rlast_o) rd_busy <= 1'b0;
        end else if (!rvalid_o && !stall_i[1]) begin
            rvalid_o <= 1'b1;   // Held until taken
        end
    end

    // Write address, data and response
    always @(posedge clk) begin
        if (!rst_n) begin
            wr_busy  <= 1'b0;
            b_pend   <= 1'b0;
            bvalid_o <= 1'b0;
        end else if (!wr_busy) begin
            if (awvalid_i && awready_o) begin
                wr_busy <= 1'b1;
                wr_ptr  <= awaddr_i[IDX_W+1:2];
            end
        end else if (!b_pend) begin
            if (wvalid_i && wready_o) begin
                mem[wr_ptr] <= wdata_i;
                wr_ptr      <= wr_ptr + 1'b1;
                b_pend      <= wlast_i;
            end
        end else if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
            b_pend   <= 1'b0;
            wr_busy  <= 1'b0;
        end else if (!bvalid_o && !stall_i[4]) begin
            bvalid_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/pad_dma_top.sv
//////////////////////////////////////////////////
// Reflect padding DMA, one pixel on each side
// Read bursts are 4 beats; AXI IDs, sizes and
// strobes are fixed by the memory side
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pad_dma_macros.svh"

module pad_dma_top (
    input  wire                       clk,
    input  wire                       rst_n,

    // Job control
    input  wire                       start_i,
    input  wire pad_dma_pkg::addr_t   src_addr_i,
    input  wire pad_dma_pkg::addr_t   dst_addr_i,
    input  wire pad_dma_pkg::width_t  width_i,
    output wire                       done_o,

    // Read address and data
    output wire pad_dma_pkg::addr_t   araddr_o,
    output wire                       arvalid_o,
    input  wire                       arready_i,
    input  wire pad_dma_pkg::word_t   rdata_i,
    input  wire                       rlast_i,
    input  wire                       rvalid_i,
    output wire                       rready_o,

    // Write address, data and response
    output wire pad_dma_pkg::addr_t   awaddr_o,
    output wire [`PD_LEN_W-1:0]       awlen_o,
    output wire                       awvalid_o,
    input  wire                       awready_i,
    output wire pad_dma_pkg::word_t   wdata_o,
    output wire                       wlast_o,
    output wire                       wvalid_o,
    input  wire                       wready_i,
    input  wire                       bvalid_i,
    output wire                       bready_o
);

    wire [`PD_ADDR_W-1:0]  src_addr;
    wire [`PD_ADDR_W-1:0]  dst_addr;
    wire [`PD_WIDTH_W-1:0] width;
    wire                   job_end;

    block_if blk ();
    tile_if  tile ();

    block_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .src_addr_i (src_addr_i),
        .dst_addr_i (dst_addr_i),
        .width_i    (width_i),
        .job_end_i  (job_end),
        .done_o     (done_o),
        .src_addr_o (src_addr),
        .dst_addr_o (dst_addr),
        .width_o    (width),
        .blk        (blk)
    );

    tile_reader u_rd (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_addr_i (src_addr),
        .width_i    (width),
        .blk        (blk),
        .tile       (tile),
        .araddr_o   (araddr_o),
        .arvalid_o  (arvalid_o),
        .arready_i  (arready_i),
        .rdata_i    (rdata_i),
        .rlast_i    (rlast_i),
        .rvalid_i   (rvalid_i),
        .rready_o   (rready_o)
    );

    pad_writer u_wr (
        .clk        (clk),
        .rst_n      (rst_n),
        .dst_addr_i (dst_addr),
        .width_i    (width),
        .tile       (tile),
        .job_end_o  (job_end),
        .awaddr_o   (awaddr_o),
        .awlen_o    (awlen_o),
        .awvalid_o  (awvalid_o),
        .awready_i  (awready_i),
        .wdata_o    (wdata_o),
        .wlast_o    (wlast_o),
        .wvalid_o   (wvalid_o),
        .wready_i   (wready_i),
        .bvalid_i   (bvalid_i),
        .bready_o   (bready_o)
    );

endmodule

`default_nettype wire

//--- source/pad_writer.sv
//////////////////////////////////////////////////
// Writes the padded rows and columns a tile owns
// Border tiles add the reflected row or column
// Every burst waits for its write response
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pad_dma_macros.svh"

module pad_writer (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire pad_dma_pkg::addr_t   dst_addr_i,
    input  wire pad_dma_pkg::width_t  width_i,
    tile_if.sink                      tile,
    output logic                      job_end_o,
    output pad_dma_pkg::addr_t        awaddr_o,
    output logic [`PD_LEN_W-1:0]      awlen_o,
    output logic                      awvalid_o,
    input  wire                       awready_i,
    output pad_dma_pkg::word_t        wdata_o,
    output logic                      wlast_o,
    output logic                      wvalid_o,
    input  wire                       wready_i,
    input  wire                       bvalid_i,
    output logic                      bready_o
);
    import pad_dma_pkg::*;

    wr_state_e  state_q;
    tile_t      tile_q;
    blk_t       bx_q, by_q;
    edge_t      edges_q;

    // Local padded index 0..5, where 1..4 are the tile itself
    logic [2:0] r_q, c_q;
    logic [2:0] r_last, c_first, c_last;

    logic [`PD_WIDTH_W:0] pad_row, pad_col, stride;

    // Reflection mapped into the tile, valid since W is a multiple of 4
    function automatic logic [1:0] src_idx(input logic [2:0] t);
        case (t)
            3'd0:    return 2'd1;          // f(-1) = 1
            3'd5:    return 2'd2;          // f(W) = W-2
            default: return 2'(t - 3'd1);
        endcase
    endfunction

    assign r_last  = 3'd4 + {2'b00, edges_q.bottom};
    assign c_first = {2'b00, ~edges_q.left};
    assign c_last  = 3'd4 + {2'b00, edges_q.right};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= WR_LOAD;
            r_q     <= '0;
            c_q     <= '0;
        end else begin
            case (state_q)
                WR_LOAD: if (tile.valid) begin
                    r_q     <= {2'b00, ~tile.edges.top};   // Row 0 only on top tiles
                    state_q <= WR_ADDR;
                end
                WR_ADDR: if (awready_i) begin
                    c_q     <= c_first;
                    state_q <= WR_DATA;
                end
                WR_DATA: if (wready_i) begin
                    if (wlast_o) begin
                        state_q <= WR_RESP;
                    end else begin
                        c_q <= c_q + 1'b1;
                    end
                end
                WR_RESP: if (bvalid_i) begin
                    if (r_q == r_last) begin
                        state_q <= WR_LOAD;
                    end else begin
                        r_q     <= r_q + 1'b1;
                        state_q <= WR_ADDR;
                    end
                end
                default: state_q <= WR_LOAD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tile.valid && tile.ready) begin
            tile_q  <= tile.tile;
            bx_q    <= tile.bx;
            by_q    <= tile.by;
            edges_q <= tile.edges;
        end
    end

    assign tile.ready = (state_q == WR_LOAD);

    // Padded coordinates and destination row pitch
    assign pad_row  = {1'b0, by_q, 2'b00} + {4'b0000, r_q};
    assign pad_col  = {1'b0, bx_q, 2'b00} + {4'b0000, c_first};
    assign stride   = {1'b0, width_i} + 2'd2;

    assign awaddr_o  = dst_addr_i + (addr_t'(pad_row) * addr_t'(stride) + addr_t'(pad_col))
                                    * addr_t'(`PD_BYTES);
    assign awlen_o   = `PD_LEN_W'(c_last - c_first);   // 4 to 6 beats
    assign awvalid_o = (state_q == WR_ADDR);

    assign wdata_o  = tile_q[src_idx(r_q)][src_idx(c_q)];
    assign wlast_o  = (c_q == c_last);
    assign wvalid_o = (state_q == WR_DATA);
    assign bready_o = (state_q == WR_RESP);

    // Final response of the bottom right tile closes the job
    assign job_end_o = (state_q == WR_RESP) && bvalid_i && (r_q == r_last)
                       && edges_q.bottom && edges_q.right;

endmodule

`default_nettype wire

//--- source/tile_reader.sv
//////////////////////////////////////////////////
// One INCR read burst per tile row, 4 beats each
// Next descriptor taken only after the tile is handed on
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pad_dma_macros.svh"

module tile_reader (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire pad_dma_pkg::addr_t   src_addr_i,
    input  wire pad_dma_pkg::width_t  width_i,
    block_if.sink                     blk,
    tile_if.source                    tile,
    output pad_dma_pkg::addr_t        araddr_o,
    output logic                      arvalid_o,
    input  wire                       arready_i,
    input  wire pad_dma_pkg::word_t   rdata_i,
    input  wire                       rlast_i,
    input  wire                       rvalid_i,
    output logic                      rready_o
);
    import pad_dma_pkg::*;

    rd_state_e  state_q;
    logic       held_q;         // Descriptor taken, tile not yet passed on
    logic [1:0] row_q, col_q;
    blk_t       bx_q, by_q;
    edge_t      edges_q;
    tile_t      tile_q;

    logic [`PD_WIDTH_W-1:0] src_row, src_col;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= RD_ADDR;
            held_q  <= 1'b0;
            row_q   <= '0;
            col_q   <= '0;
        end else begin
            case (state_q)
                RD_ADDR: begin
                    if (blk.valid && blk.ready) begin
                        held_q <= 1'b1;
                        row_q  <= '0;
                    end else if (arvalid_o && arready_i) begin
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: if (rvalid_i) begin
                    col_q <= col_q + 1'b1;
                    if (rlast_i) begin
                        col_q <= '0;
                        if (row_q == `PD_TILE - 1) begin
                            state_q <= RD_HOLD;
                        end else begin
                            row_q   <= row_q + 1'b1;
                            state_q <= RD_ADDR;
                        end
                    end
                end
                RD_HOLD: if (tile.ready) begin
                    held_q  <= 1'b0;
                    state_q <= RD_ADDR;
                end
                default: state_q <= RD_ADDR;
            endcase
        end
    end

    // Descriptor and tile words
    always_ff @(posedge clk) begin
        if (blk.valid && blk.ready) begin
            bx_q    <= blk.bx;
            by_q    <= blk.by;
            edges_q <= blk.edges;
        end
        if (rvalid_i && rready_o) begin
            tile_q[row_q][col_q] <= rdata_i;
        end
    end

    assign blk.ready = (state_q == RD_ADDR) && !held_q;

    // Source row is 4*by + row, column 4*bx
    assign src_row   = {by_q, row_q};
    assign src_col   = {bx_q, 2'b00};
    assign araddr_o  = src_addr_i + (addr_t'(src_row) * addr_t'(width_i) + addr_t'(src_col))
                                    * addr_t'(`PD_BYTES);
    assign arvalid_o = (state_q == RD_ADDR) && held_q;
    assign rready_o  = (state_q == RD_DATA);

    assign tile.valid = (state_q == RD_HOLD);
    assign tile.tile  = tile_q;
    assign tile.bx    = bx_q;
    assign tile.by    = by_q;
    assign tile.edges = edges_q;

endmodule

`default_nettype wire

//--- source/block_sequencer.sv
//////////////////////////////////////////////////
// Starts only from done with a nonzero width, multiple of 4
// Job fields stay fixed until done rises again
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "pad_dma_macros.svh"

module block_sequencer (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start_i,
    input  wire pad_dma_pkg::addr_t   src_addr_i,
    input  wire pad_dma_pkg::addr_t   dst_addr_i,
    input  wire pad_dma_pkg::width_t  width_i,
    input  wire                       job_end_i,
    output logic                      done_o,
    output pad_dma_pkg::addr_t        src_addr_o,
    output pad_dma_pkg::addr_t        dst_addr_o,
    output pad_dma_pkg::width_t       width_o,
    block_if.source                   blk
);
    import pad_dma_pkg::*;

    seq_state_e  state_q;
    addr_t       src_q, dst_q;
    width_t      width_q;
    blk_t        bx_q, by_q;
    blk_t        last_idx;
    logic        accept;

    assign accept   = start_i && done_o && (width_i != '0) && (width_i[1:0] == 2'b00);
    assign last_idx = width_q[`PD_WIDTH_W-1:2] - 1'b1;   // Tiles per axis minus one

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= SEQ_IDLE;
            done_o  <= 1'b1;
            bx_q    <= '0;
            by_q    <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: if (accept) begin
                    done_o  <= 1'b0;
                    bx_q    <= '0;
                    by_q    <= '0;
                    state_q <= SEQ_ISSUE;
                end
                SEQ_ISSUE: if (blk.valid && blk.ready) begin
                    if (bx_q == last_idx && by_q == last_idx) begin
                        state_q <= SEQ_BUSY;   // Last tile handed off
                    end else if (bx_q == last_idx) begin
                        bx_q <= '0;
                        by_q <= by_q + 1'b1;
                    end else begin
                        bx_q <= bx_q + 1'b1;
                    end
                end
                SEQ_BUSY: if (job_end_i) begin
                    done_o  <= 1'b1;
                    state_q <= SEQ_IDLE;
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            src_q   <= src_addr_i;
            dst_q   <= dst_addr_i;
            width_q <= width_i;
        end
    end

    assign blk.valid  = (state_q == SEQ_ISSUE);
    assign blk.bx     = bx_q;
    assign blk.by     = by_q;
    assign blk.edges  = {by_q == '0, by_q == last_idx, bx_q == '0, bx_q == last_idx};

    assign src_addr_o = src_q;
    assign dst_addr_o = dst_q;
    assign width_o    = width_q;

endmodule

`default_nettype wire

//--- source/pad_dma_if.sv
//////////////////////////////////////////////////
// Stage links, payload held stable while valid
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

// Tile descriptor, sequencer to reader
interface block_if;
    import pad_dma_pkg::*;

    logic   valid;
    logic   ready;
    blk_t   bx;
    blk_t   by;
    edge_t  edges;

    modport source (output valid, bx, by, edges, input ready);
    modport sink   (input valid, bx, by, edges, output ready);
endinterface

// Filled tile with its descriptor, reader to writer
interface tile_if;
    import pad_dma_pkg::*;

    logic   valid;
    logic   ready;
    tile_t  tile;
    blk_t   bx;
    blk_t   by;
    edge_t  edges;

    modport source (output valid, tile, bx, by, edges, input ready);
    modport sink   (input valid, tile, bx, by, edges, output ready);
endinterface

`default_nettype wire

//--- source/pad_dma_pkg.sv
//////////////////////////////////////////////////
// Shared types for the padding DMA
// Tile index fits W/4 tiles of a side up to 60
//////////////////////////////////////////////////

`default_nettype none

`include "pad_dma_macros.svh"

package pad_dma_pkg;

    typedef logic [`PD_ADDR_W-1:0]    addr_t;
    typedef logic [`PD_DATA_W-1:0]    word_t;
    typedef logic [`PD_WIDTH_W-1:0]   width_t;
    typedef logic [`PD_WIDTH_W-3:0]   blk_t;   // Side divided by tile size

    // Borders touched by a tile
    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } edge_t;

    typedef word_t [`PD_TILE-1:0][`PD_TILE-1:0] tile_t;   // [row][col]

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_BUSY} seq_state_e;
    typedef enum logic [1:0] {RD_ADDR, RD_DATA, RD_HOLD} rd_state_e;
    typedef enum logic [1:0] {WR_LOAD, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

endpackage

`default_nettype wire

//--- source/pad_dma_macros.svh
//////////////////////////////////////////////////
// Widths and tile geometry for the padding DMA
// Matrix side must be a multiple of PD_TILE, at most 60
//////////////////////////////////////////////////

`ifndef PAD_DMA_MACROS_SVH
`define PAD_DMA_MACROS_SVH

// Bus widths
`define PD_ADDR_W  32
`define PD_DATA_W  32

// Matrix side, up to 63 but only multiples of 4 are accepted
`define PD_WIDTH_W 6

// Square tile side in words
`define PD_TILE    4

`define PD_BYTES   4   // Bytes per beat
`define PD_LEN_W   4   // AXI burst length field

`endif
